// File: verilog/lsu_types_pkg.sv
/*
 * load unit type definitions
 * data and address widths, integer load operations,
 * bypass queue request and load buffer entry
 */
`default_nettype none

package lsu_types_pkg;

  // ------------------------------------------------------------
  // widths
  // ------------------------------------------------------------
  // 64-bit data path, load data and result
  typedef logic [63:0] xlen_data_t;
  // sv39 virtual address, also used as physical address
  typedef logic [38:0] vaddr_t;
  // scoreboard transaction id
  typedef logic [2:0]  trans_id_t;
  // byte position inside the 64-bit word
  typedef logic [2:0]  byte_offset_t;
  // one enable per byte of the word
  typedef logic [7:0]  byte_en_t;

  // integer loads, U suffix means zero extension
  typedef enum logic [2:0] {
    LD,
    LW,
    LWU,
    LH,
    LHU,
    LB,
    LBU
  } ld_op_e;

  // request as it comes out of the bypass queue
  typedef struct packed {
    vaddr_t    vaddr;
    trans_id_t trans_id;
    ld_op_e    operation;
    byte_en_t  be;
  } lsu_ctrl_t;

  // what must survive until the response comes back
  typedef struct packed {
    trans_id_t    trans_id;
    byte_offset_t byte_offset;
    ld_op_e       operation;
  } ldbuf_entry_t;

endpackage

`default_nettype wire

// File: verilog/dcache_port_pkg.sv
/*
 * data cache load port
 * index, tag and request id widths,
 * request and response structs
 */
`default_nettype none

package dcache_port_pkg;

  // low address bits, sent with the request
  typedef logic [11:0] dcache_index_t;
  // address bits 38 down to 12, sent one cycle after the grant
  typedef logic [26:0] dcache_tag_t;
  // request id carries the load buffer slot, so at most 16 slots
  typedef logic [3:0]  dcache_id_t;

  // load unit towards the cache
  typedef struct packed {
    logic                    data_req;
    dcache_index_t           address_index;
    dcache_tag_t             address_tag;
    logic                    tag_valid;
    logic                    kill_req;
    lsu_types_pkg::byte_en_t data_be;
    // log2 of the access size in bytes
    logic [1:0]              data_size;
    dcache_id_t              data_id;
  } dcache_req_t;

  // cache towards the load unit
  typedef struct packed {
    logic                      data_gnt;
    logic                      data_rvalid;
    dcache_id_t                data_rid;
    lsu_types_pkg::xlen_data_t data_rdata;
  } dcache_rsp_t;

endpackage

`default_nettype wire

// File: verilog/ld_issue_ctrl.sv
/*
 * load issue controller
 * request FSM towards the data cache, lowest free slot search,
 * load buffer allocation and tag register
 */
`timescale 1ns/10ps
`default_nettype none

module ld_issue_ctrl
  import lsu_types_pkg::*;
  import dcache_port_pkg::*;
#(
  parameter int unsigned NR_LDBUF = 4
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                flush_i,
  input  logic                valid_i,
  input  lsu_ctrl_t           lsu_ctrl_i,
  input  logic                rsp_gnt_i,
  input  logic [NR_LDBUF-1:0] slot_valid_i,
  output logic                pop_ld_o,
  output dcache_req_t         req_o,
  output logic [NR_LDBUF-1:0] alloc_o,
  output ldbuf_entry_t        alloc_entry_o,
  output logic                flush_o
);

  typedef enum logic [1:0] {
    IDLE,
    WAIT_GNT,
    SEND_TAG,
    WAIT_FLUSH
  } ld_state_e;

  ld_state_e    state_d, state_q;
  dcache_id_t   free_idx;
  logic         free_found;
  logic         accept;
  logic         grant;
  byte_offset_t req_off;
  dcache_tag_t  tag_q;

  // ------------------------------------------------------------
  // free slot search
  // ------------------------------------------------------------
  // walk down so the lowest free index is the last one written
  always_comb begin
    free_idx   = '0;
    free_found = 1'b0;
    for (int i = NR_LDBUF - 1; i >= 0; i--) begin
      if (!slot_valid_i[i]) begin
        free_idx   = dcache_id_t'(i);
        free_found = 1'b1;
      end
    end
  end

  // no new request while the pipeline is being flushed
  assign accept  = valid_i && free_found && !flush_i;
  assign grant   = req_o.data_req && rsp_gnt_i;
  assign req_off = lsu_ctrl_i.vaddr[2:0];

  // ------------------------------------------------------------
  // request FSM
  // ------------------------------------------------------------
  always_comb begin
    state_d             = state_q;
    pop_ld_o            = 1'b0;
    req_o.data_req      = 1'b0;
    req_o.tag_valid     = 1'b0;
    req_o.kill_req      = 1'b0;
    req_o.address_index = lsu_ctrl_i.vaddr[11:0];
    // tag of the request granted in the previous cycle
    req_o.address_tag   = tag_q;
    req_o.data_be       = lsu_ctrl_i.be;
    req_o.data_id       = free_idx;
    unique case (lsu_ctrl_i.operation)
      LW, LWU: req_o.data_size = 2'd2;
      LH, LHU: req_o.data_size = 2'd1;
      LB, LBU: req_o.data_size = 2'd0;
      default: req_o.data_size = 2'd3;
    endcase

    unique case (state_q)
      // a new index may go out while the previous tag is sent
      IDLE, SEND_TAG: begin
        if (state_q == SEND_TAG) begin
          req_o.tag_valid = 1'b1;
          req_o.kill_req  = flush_i;
          state_d         = IDLE;
        end
        if (accept) begin
          req_o.data_req = 1'b1;
          if (rsp_gnt_i) begin
            state_d  = SEND_TAG;
            pop_ld_o = 1'b1;
          end else begin
            state_d = WAIT_GNT;
          end
        end
      end
      // hold the index until the cache takes it
      WAIT_GNT: begin
        req_o.data_req = !flush_i;
        if (rsp_gnt_i && !flush_i) begin
          state_d  = SEND_TAG;
          pop_ld_o = 1'b1;
        end
      end
      // kill whatever the cache arbiter still holds
      WAIT_FLUSH: begin
        req_o.kill_req  = 1'b1;
        req_o.tag_valid = 1'b1;
        state_d         = IDLE;
      end
      default: state_d = IDLE;
    endcase

    if (flush_i) begin
      state_d = WAIT_FLUSH;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // physical address equals virtual address, so the tag is known at grant
  always_ff @(posedge clk_i) begin
    if (grant) begin
      tag_q <= lsu_ctrl_i.vaddr[38:12];
    end
  end

  // ------------------------------------------------------------
  // load buffer allocation
  // ------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < NR_LDBUF; i++) begin
      alloc_o[i] = grant && free_found && (free_idx == dcache_id_t'(i));
    end
  end

  assign alloc_entry_o = '{
    trans_id:    lsu_ctrl_i.trans_id,
    byte_offset: req_off,
    operation:   lsu_ctrl_i.operation
  };
  assign flush_o = flush_i;

  a_alloc_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(alloc_o))
    else $error("load buffer allocation is not one-hot");

  // slot state comes back from the slot array
  a_alloc_free: assert property (@(posedge clk_i) disable iff (!rst_ni)
    grant |-> (|alloc_o && ((alloc_o & slot_valid_i) == '0)))
    else $error("grant allocated an occupied load buffer slot");

  // misaligned accesses must have been trapped upstream
  a_offset: assert property (@(posedge clk_i) disable iff (!rst_ni)
    grant |-> ((!(lsu_ctrl_i.operation inside {LW, LWU}) || req_off < 3'd5) &&
               (!(lsu_ctrl_i.operation inside {LH, LHU}) || req_off < 3'd7)))
    else $error("misaligned load offset at grant");

endmodule

`default_nettype wire

// File: verilog/ldbuf_slot.sv
/*
 * one load buffer entry
 * valid and flushed flags plus the stored entry
 */
`timescale 1ns/10ps
`default_nettype none

module ldbuf_slot
  import lsu_types_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         alloc_i,
  input  logic         release_i,
  input  logic         flush_i,
  input  ldbuf_entry_t entry_i,
  output logic         valid_o,
  output logic         flushed_o,
  output ldbuf_entry_t entry_o
);

  logic         valid_q;
  logic         flushed_q;
  ldbuf_entry_t entry_q;

  // alloc wins, a new load is never flushed
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q   <= 1'b0;
      flushed_q <= 1'b0;
    end else begin
      if (alloc_i) begin
        valid_q   <= 1'b1;
        flushed_q <= 1'b0;
      end else begin
        if (release_i) begin
          valid_q <= 1'b0;
        end
        // mark in-flight loads, their response is dropped later
        if (flush_i) begin
          flushed_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (alloc_i) begin
      entry_q <= entry_i;
    end
  end

  assign valid_o   = valid_q;
  assign flushed_o = flushed_q;
  assign entry_o   = entry_q;

  // issue and retire side must not hit the same busy slot
  a_alloc_release: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_q |-> !(alloc_i && release_i))
    else $error("alloc and release on a valid slot");

endmodule

`default_nettype wire

// File: verilog/ld_retire.sv
/*
 * load retire logic
 * response slot lookup and release,
 * data realignment and sign or zero extension
 */
`timescale 1ns/10ps
`default_nettype none

module ld_retire
  import lsu_types_pkg::*;
  import dcache_port_pkg::*;
#(
  parameter int unsigned NR_LDBUF = 4
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  dcache_rsp_t                rsp_i,
  input  logic         [NR_LDBUF-1:0] slot_valid_i,
  input  logic         [NR_LDBUF-1:0] slot_flushed_i,
  input  ldbuf_entry_t [NR_LDBUF-1:0] slot_entry_i,
  output logic         [NR_LDBUF-1:0] release_o,
  output logic                       valid_o,
  output trans_id_t                  trans_id_o,
  output xlen_data_t                 result_o
);

  ldbuf_entry_t rd_entry;
  logic         rd_valid;
  logic         rd_flushed;
  xlen_data_t   shifted;
  logic [7:0]   sign_bits;
  byte_offset_t sign_pos;
  logic         is_signed;
  logic         sign_bit;

  // ------------------------------------------------------------
  // slot lookup
  // ------------------------------------------------------------
  // response id is the slot index given at grant
  always_comb begin
    rd_entry   = '0;
    rd_valid   = 1'b0;
    rd_flushed = 1'b0;
    for (int i = 0; i < NR_LDBUF; i++) begin
      release_o[i] = rsp_i.data_rvalid && (rsp_i.data_rid == dcache_id_t'(i));
      if (rsp_i.data_rid == dcache_id_t'(i)) begin
        rd_entry   = slot_entry_i[i];
        rd_valid   = slot_valid_i[i];
        rd_flushed = slot_flushed_i[i];
      end
    end
  end

  // flushed loads are freed but never reported
  assign valid_o    = rsp_i.data_rvalid && rd_valid && !rd_flushed;
  assign trans_id_o = rd_entry.trans_id;

  // ------------------------------------------------------------
  // realign and extend
  // ------------------------------------------------------------
  assign shifted = rsp_i.data_rdata >> {rd_entry.byte_offset, 3'b000};

  // top bit of every byte, picked in parallel with the shifter
  for (genvar i = 0; i < 8; i++) begin : gen_sign_bits
    assign sign_bits[i] = rsp_i.data_rdata[8*i+7];
  end

  // sign lives in the highest byte of the accessed field
  always_comb begin
    unique case (rd_entry.operation)
      LW, LWU: sign_pos = byte_offset_t'(rd_entry.byte_offset + 3'd3);
      LH, LHU: sign_pos = byte_offset_t'(rd_entry.byte_offset + 3'd1);
      default: sign_pos = rd_entry.byte_offset;
    endcase
  end

  assign is_signed = rd_entry.operation inside {LW, LH, LB};
  // unsigned loads fill with zeros
  assign sign_bit  = is_signed && sign_bits[sign_pos];

  always_comb begin
    unique case (rd_entry.operation)
      LW, LWU: result_o = {{32{sign_bit}}, shifted[31:0]};
      LH, LHU: result_o = {{48{sign_bit}}, shifted[15:0]};
      LB, LBU: result_o = {{56{sign_bit}}, shifted[7:0]};
      default: result_o = shifted;
    endcase
  end

  // cache may only answer requests that still own a slot
  a_rid_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_i.data_rvalid |-> |(release_o & slot_valid_i))
    else $error("response id names no valid load buffer slot");

endmodule

`default_nettype wire

// File: verilog/load_unit.sv
/*
 * load unit top level
 * issue controller, load buffer slot array and retire logic
 */
`timescale 1ns/10ps
`default_nettype none

module load_unit
  import lsu_types_pkg::*;
  import dcache_port_pkg::*;
#(
  // 2 to 16 slots, the slot index travels as the cache request id
  parameter int unsigned NR_LDBUF = 4
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        flush_i,
  input  logic        valid_i,
  input  lsu_ctrl_t   lsu_ctrl_i,
  output logic        pop_ld_o,
  output dcache_req_t req_port_o,
  input  dcache_rsp_t req_port_i,
  output logic        valid_o,
  output trans_id_t   trans_id_o,
  output xlen_data_t  result_o
);

  logic         [NR_LDBUF-1:0] slot_valid;
  logic         [NR_LDBUF-1:0] slot_flushed;
  logic         [NR_LDBUF-1:0] slot_alloc;
  logic         [NR_LDBUF-1:0] slot_release;
  ldbuf_entry_t [NR_LDBUF-1:0] slot_entry;
  ldbuf_entry_t                alloc_entry;
  logic                        slot_flush;

  // ------------------------------------------------------------
  // issue side
  // ------------------------------------------------------------
  ld_issue_ctrl #(
    .NR_LDBUF (NR_LDBUF)
  ) u_issue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .valid_i       (valid_i),
    .lsu_ctrl_i    (lsu_ctrl_i),
    .rsp_gnt_i     (req_port_i.data_gnt),
    .slot_valid_i  (slot_valid),
    .pop_ld_o      (pop_ld_o),
    .req_o         (req_port_o),
    .alloc_o       (slot_alloc),
    .alloc_entry_o (alloc_entry),
    .flush_o       (slot_flush)
  );

  // one entry per outstanding load
  for (genvar i = 0; i < NR_LDBUF; i++) begin : gen_slot
    ldbuf_slot u_slot (
      .clk_i     (clk_i),
      .rst_ni    (rst_ni),
      .alloc_i   (slot_alloc[i]),
      .release_i (slot_release[i]),
      .flush_i   (slot_flush),
      .entry_i   (alloc_entry),
      .valid_o   (slot_valid[i]),
      .flushed_o (slot_flushed[i]),
      .entry_o   (slot_entry[i])
    );
  end

  // ------------------------------------------------------------
  // response side
  // ------------------------------------------------------------
  ld_retire #(
    .NR_LDBUF (NR_LDBUF)
  ) u_retire (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .rsp_i          (req_port_i),
    .slot_valid_i   (slot_valid),
    .slot_flushed_i (slot_flushed),
    .slot_entry_i   (slot_entry),
    .release_o      (slot_release),
    .valid_o        (valid_o),
    .trans_id_o     (trans_id_o),
    .result_o       (result_o)
  );

endmodule

`default_nettype wire

// File: dv/tb_clk_gen.sv
/*
 * testbench clock and reset generator
 * 10 ns clock, active low reset for 8 cycles
 */
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (8) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

`default_nettype wire

// File: dv/tb_load_unit.sv
/*
 * load unit testbench
 * cache model, directed tests, compare tasks and verdict
 */
`timescale 1ns/10ps
`default_nettype none

module tb_load_unit
  import lsu_types_pkg::*;
  import dcache_port_pkg::*;
();

  logic        clk, rst_n, flush_i, valid_i, pop_ld_o, valid_o;
  lsu_ctrl_t   lsu_ctrl_i;
  dcache_req_t req_port_o;
  dcache_rsp_t req_port_i;
  trans_id_t   trans_id_o;
  xlen_data_t  result_o;
  logic [31:0] rnd;
  int          pop_cnt, val_cnt;
  logic        kill_seen;
  // cache model bookkeeping per granted id
  vaddr_t      pend_addr [16];
  ld_op_e      pend_op [16];
  trans_id_t   pend_tid [16];

  tb_clk_gen u_clk_gen (.clk_o(clk), .rst_no(rst_n));

  load_unit #(.NR_LDBUF(4)) u_load_unit (
    .clk_i(clk), .rst_ni(rst_n), .flush_i(flush_i), .valid_i(valid_i),
    .lsu_ctrl_i(lsu_ctrl_i), .pop_ld_o(pop_ld_o), .req_port_o(req_port_o),
    .req_port_i(req_port_i), .valid_o(valid_o), .trans_id_o(trans_id_o),
    .result_o(result_o)
  );

  // ------------------------------------------------------------
  // monitor, sampled mid cycle where outputs are stable
  // ------------------------------------------------------------
  always @(negedge clk) begin
    if (rst_n) begin
      pop_cnt += int'(pop_ld_o);
      val_cnt += int'(valid_o);
      if (req_port_o.kill_req) kill_seen = 1'b1;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // memory content depends on the whole word address
  function automatic xlen_data_t mem_word(input vaddr_t a);
    logic [63:0] w;
    w = {28'h0, a[38:3]};
    return (w * 64'h9e37_79b9_7f4a_7c15) ^ {w[31:0], w[63:32]};
  endfunction

  // shift down by the offset, truncate and extend per operation
  function automatic xlen_data_t expected_load(input xlen_data_t word, input ld_op_e op,
                                               input byte_offset_t off);
    xlen_data_t sh;
    sh = word >> (int'(off) * 8);
    case (op)
      LW:  return {{32{sh[31]}}, sh[31:0]};
      LWU: return {32'h0, sh[31:0]};
      LH:  return {{48{sh[15]}}, sh[15:0]};
      LHU: return {48'h0, sh[15:0]};
      LB:  return {{56{sh[7]}}, sh[7:0]};
      LBU: return {56'h0, sh[7:0]};
      default: return sh;
    endcase
  endfunction

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_result(input string name, input xlen_data_t exp, input xlen_data_t act);
    if (exp !== act) begin
      $display("** Error: %s expected %h actual %h", name, exp, act);
      report_failure("result mismatch");
    end
  endtask

  task automatic check_trans_id(input string name, input trans_id_t exp, input trans_id_t act);
    if (exp !== act) begin
      $display("** Error: %s expected %0d actual %0d", name, exp, act);
      report_failure("transaction id mismatch");
    end
  endtask

  task automatic check_tag(input string name, input dcache_tag_t exp, input dcache_tag_t act);
    if (exp !== act) begin
      $display("** Error: %s expected %h actual %h", name, exp, act);
      report_failure("cache tag mismatch");
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (exp != act) begin
      $display("** Error: %s expected %0d actual %0d", name, exp, act);
      report_failure("count mismatch");
    end
  endtask

  // present one load and grant it after a random delay of 0 to 3 cycles
  task automatic issue_load(input string name, input vaddr_t addr, input ld_op_e op,
                            input trans_id_t tid, output dcache_id_t id);
    int   delay;
    int   t;
    logic done;
    rnd   = xorshift(rnd);
    delay = int'(rnd % 4);
    done  = 1'b0;
    t     = 0;
    @(posedge clk);
    #1;
    valid_i    = 1'b1;
    lsu_ctrl_i = '{vaddr: addr, trans_id: tid, operation: op, be: 8'hff};
    while (!done) begin
      req_port_i.data_gnt = (delay == 0);
      @(negedge clk);
      if (req_port_o.data_req && req_port_i.data_gnt) begin
        id            = req_port_o.data_id;
        pend_addr[id] = addr;
        pend_op[id]   = op;
        pend_tid[id]  = tid;
        done          = 1'b1;
        check_count({name, " pop at grant"}, 1, int'(pop_ld_o));
      end else if (delay > 0) begin
        delay--;
      end
      t++;
      if (t > 50) report_failure("load was never granted by the handshake");
      @(posedge clk);
      #1;
    end
    valid_i             = 1'b0;
    req_port_i.data_gnt = 1'b0;
    // tag phase follows one cycle after the grant
    @(negedge clk);
    check_count({name, " tag_valid"}, 1, int'(req_port_o.tag_valid));
    check_tag({name, " tag"}, addr[38:12], req_port_o.address_tag);
  endtask

  // return the response for one id and check what the unit reports
  task automatic respond_and_check(input string name, input dcache_id_t id,
                                   input logic want_valid);
    xlen_data_t word;
    word = mem_word(pend_addr[id]);
    @(posedge clk);
    #1;
    req_port_i.data_rvalid = 1'b1;
    req_port_i.data_rid    = id;
    req_port_i.data_rdata  = word;
    @(negedge clk);
    check_count({name, " valid"}, int'(want_valid), int'(valid_o));
    if (want_valid) begin
      check_trans_id(name, pend_tid[id], trans_id_o);
      check_result(name, expected_load(word, pend_op[id], pend_addr[id][2:0]), result_o);
    end
    @(posedge clk);
    #1;
    req_port_i.data_rvalid = 1'b0;
  endtask

  // ------------------------------------------------------------
  // directed tests
  // ------------------------------------------------------------
  task automatic test_reset_idle();
    repeat (10) begin
      @(negedge clk);
      check_count("reset_idle data_req", 0, int'(req_port_o.data_req));
      check_count("reset_idle pop", 0, int'(pop_ld_o));
      check_count("reset_idle valid", 0, int'(valid_o));
    end
  endtask

  task automatic test_all_ops();
    dcache_id_t id;
    int         max_off;
    for (int k = 0; k < 7; k++) begin
      max_off = (k == 0) ? 0 : (k < 3) ? 4 : (k < 5) ? 6 : 7;
      for (int off = 0; off <= max_off; off++) begin
        rnd = xorshift(rnd);
        issue_load("all_ops", {rnd, 4'(k), 3'(off)}, ld_op_e'(k), trans_id_t'(off), id);
        respond_and_check("all_ops", id, 1'b1);
      end
    end
  endtask

  task automatic test_back_to_back();
    dcache_id_t ids[$];
    dcache_id_t id;
    int         pop0, val0;
    pop0 = pop_cnt;
    val0 = val_cnt;
    for (int i = 0; i < 8; i++) begin
      rnd = xorshift(rnd);
      issue_load("back_to_back", {rnd, 7'(i * 8)}, ld_op_e'(i % 7), trans_id_t'(i), id);
      ids.push_back(id);
      if (ids.size() == 2) respond_and_check("back_to_back", ids.pop_front(), 1'b1);
    end
    while (ids.size() > 0) respond_and_check("back_to_back", ids.pop_front(), 1'b1);
    @(negedge clk);
    check_count("back_to_back pops", 8, pop_cnt - pop0);
    check_count("back_to_back valids", 8, val_cnt - val0);
  endtask

  task automatic test_backpressure();
    dcache_id_t ids[$];
    dcache_id_t id;
    int         pop0;
    pop0 = pop_cnt;
    for (int i = 0; i < 4; i++) begin
      rnd = xorshift(rnd);
      issue_load("backpressure", {rnd, 7'(i * 8)}, LD, trans_id_t'(i + 3), id);
      ids.push_back(id);
    end
    @(posedge clk);
    #1;
    valid_i             = 1'b1;
    req_port_i.data_gnt = 1'b1;
    repeat (6) begin
      @(negedge clk);
      check_count("backpressure data_req", 0, int'(req_port_o.data_req));
    end
    @(posedge clk);
    #1;
    valid_i             = 1'b0;
    req_port_i.data_gnt = 1'b0;
    check_count("backpressure pops", 4, pop_cnt - pop0);
    while (ids.size() > 0) respond_and_check("backpressure", ids.pop_back(), 1'b1);
  endtask

  task automatic test_flush();
    dcache_id_t ids[$];
    dcache_id_t id;
    int         val0;
    kill_seen = 1'b0;
    for (int i = 0; i < 3; i++) begin
      rnd = xorshift(rnd);
      issue_load("flush", {rnd, 7'(i * 8 + 4)}, LW, trans_id_t'(i), id);
      ids.push_back(id);
    end
    @(posedge clk);
    #1;
    flush_i = 1'b1;
    @(posedge clk);
    #1;
    flush_i = 1'b0;
    val0    = val_cnt;
    while (ids.size() > 0) respond_and_check("flush", ids.pop_front(), 1'b0);
    check_count("flush valids", 0, val_cnt - val0);
    check_count("flush kill_req", 1, int'(kill_seen));
    rnd = xorshift(rnd);
    issue_load("after_flush", {rnd, 7'h26}, LH, 3'd7, id);
    respond_and_check("after_flush", id, 1'b1);
  endtask

  initial begin
    int t;
    rnd        = 32'h9eac_07cf;
    pop_cnt    = 0;
    val_cnt    = 0;
    kill_seen  = 1'b0;
    flush_i    = 1'b0;
    valid_i    = 1'b0;
    lsu_ctrl_i = '0;
    req_port_i = '0;
    t          = 0;
    while (!rst_n) begin
      @(posedge clk);
      t++;
      if (t > 50) report_failure("reset was never released");
    end
    test_reset_idle();
    test_all_ops();
    test_back_to_back();
    test_backpressure();
    test_flush();
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
verilog/lsu_types_pkg.sv
verilog/dcache_port_pkg.sv
verilog/ld_issue_ctrl.sv
verilog/ldbuf_slot.sv
verilog/ld_retire.sv
verilog/load_unit.sv
dv/tb_clk_gen.sv
dv/tb_load_unit.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f flist.f --top-module tb_load_unit \
		-o Vtb_load_unit

run: compile
	out=$$(./obj_dir/Vtb_load_unit); \
	echo "$$out"; \
	echo "$$out" | grep -q "all tests passed"

clean:
	rm -rf obj_dir
